//--- Makefile
# Verilator build and run of the signal router testbench

VERILATOR ?= verilator
TOP       ?= tb_sig_router
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) hdl/sig_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/bus_pkg.sv
`include "sig_config.svh"

package bus_pkg;

    typedef logic [`BUS_W-1:0] bus_data_t;   // rdata / wdata word

    // ------------------------------
    // register map
    // ------------------------------
    typedef enum logic [`ADDR_DEC_W-1:0] {
        // switch registers, read/write
        osc_a_sel = 'h00,    // scope channel a source
        osc_b_sel = 'h04,    // scope channel b source
        osc_ctrl  = 'h08,    // [osc2_filt_off, osc1_filt_off]
        trig_sel  = 'h0C,    // trigger source
        out1_sel  = 'h10,    // fast dac 1 source
        out2_sel  = 'h14,    // fast dac 2 source
        slow3_sel = 'h20,    // slow dac 3 source
        slow4_sel = 'h24,    // slow dac 4 source
        // live signals, read only
        in1       = 'h28,    // adc in1, sign extended
        in2       = 'h2C,    // adc in2, sign extended
        out1      = 'h30,    // fast dac 1
        out2      = 'h34,    // fast dac 2
        slow3     = 'h40,    // slow dac 3 code
        slow4     = 'h44,    // slow dac 4 code
        osc_a     = 'h48,    // scope channel a
        osc_b     = 'h4C     // scope channel b
    } reg_addr_e;

    // 0x18, 0x1C, 0x38, 0x3C and 0x50 up are holes now
    // they fall to the default read of zero

endpackage

//--- hdl/dac_route.sv
`timescale 1ns/10ps
`include "sig_config.svh"

module dac_route (
    input  logic                  clk,
    input  logic                  rst,
    input  route_pkg::sample_t    i_in1,
    input  route_pkg::sample_t    i_in2,
    output route_pkg::sample_t    o_out1,   // fast, no latency
    output route_pkg::sample_t    o_out2,
    output route_pkg::slow_code_t o_slow3,  // five cycles behind input
    output route_pkg::slow_code_t o_slow4,
    route_cfg_if.dac              cfg,
    route_mon_if.dac              mon
);

    // most negative sample, scales to code 0
    localparam route_pkg::sample_t MID_SCALE = {1'b1, {(`SIG_W-1){1'b0}}};

    route_pkg::sample_t slow3_q;   // registered slow selections
    route_pkg::sample_t slow4_q;

    // shared mux, idle value differs per path
    function automatic route_pkg::sample_t pick(input route_pkg::dac_src_e sel,
                                                input route_pkg::sample_t  a,
                                                input route_pkg::sample_t  b,
                                                input route_pkg::sample_t  idle);
        case (sel)
            route_pkg::dac_in1: return a;
            route_pkg::dac_in2: return b;
            default:            return idle;
        endcase
    endfunction

    // ------------------------------
    // fast dacs
    // ------------------------------
    assign o_out1 = pick(cfg.out1_sel, i_in1, i_in2, '0);
    assign o_out2 = pick(cfg.out2_sel, i_in1, i_in2, '0);

    // ------------------------------
    // slow dacs
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slow3_q <= MID_SCALE;   // idle level
            slow4_q <= MID_SCALE;
        end else begin
            slow3_q <= pick(cfg.slow3_sel, i_in1, i_in2, MID_SCALE);
            slow4_q <= pick(cfg.slow4_sel, i_in1, i_in2, MID_SCALE);
        end
    end

    slow_dac_scale u_scale3 (.clk(clk), .rst(rst), .i_sample(slow3_q), .o_code(o_slow3));
    slow_dac_scale u_scale4 (.clk(clk), .rst(rst), .i_sample(slow4_q), .o_code(o_slow4));

    assign mon.out1  = o_out1;
    assign mon.out2  = o_out2;
    assign mon.slow3 = o_slow3;
    assign mon.slow4 = o_slow4;

endmodule

//--- hdl/route_if.sv
`timescale 1ns/10ps

// switch settings from the register bank to the routers
interface route_cfg_if;

    route_pkg::scope_src_e osc_a_sel;   // scope a mux
    route_pkg::scope_src_e osc_b_sel;   // scope b mux
    route_pkg::trig_src_e  trig_sel;    // trigger mux
    route_pkg::dac_src_e   out1_sel;    // fast dac 1 mux
    route_pkg::dac_src_e   out2_sel;    // fast dac 2 mux
    route_pkg::dac_src_e   slow3_sel;   // slow dac 3 mux
    route_pkg::dac_src_e   slow4_sel;   // slow dac 4 mux

    modport regs  (output osc_a_sel, osc_b_sel, trig_sel,
                   out1_sel, out2_sel, slow3_sel, slow4_sel);
    modport scope (input osc_a_sel, osc_b_sel, trig_sel);
    modport dac   (input out1_sel, out2_sel, slow3_sel, slow4_sel);

endinterface

// live values back to the register bank for read-back
interface route_mon_if;

    route_pkg::sample_t    in1;         // adc inputs as seen by the router
    route_pkg::sample_t    in2;
    route_pkg::sample_t    osc_a;       // registered scope channels
    route_pkg::sample_t    osc_b;
    route_pkg::sample_t    out1;        // fast dac outputs
    route_pkg::sample_t    out2;
    route_pkg::slow_code_t slow3;       // scaled slow dac codes
    route_pkg::slow_code_t slow4;

    modport scope (output in1, in2, osc_a, osc_b);
    modport dac   (output out1, out2, slow3, slow4);
    modport regs  (input in1, in2, osc_a, osc_b, out1, out2, slow3, slow4);

endinterface

//--- hdl/route_pkg.sv
`include "sig_config.svh"

package route_pkg;

    // ------------------------------
    // sample and code types
    // ------------------------------
    typedef logic signed [`SIG_W-1:0] sample_t;     // two's complement adc/dac sample
    typedef logic        [`SLOW_W-1:0] slow_code_t; // straight binary slow dac code

    // ------------------------------
    // source selects
    // ------------------------------

    // scope channel mux, unused codes read as zero
    typedef enum logic [4:0] {
        scope_zero = 5'd0,   // grounded
        scope_in1  = 5'd1,   // adc in1
        scope_in2  = 5'd2    // adc in2
    } scope_src_e;

    // fast and slow dac mux
    typedef enum logic [3:0] {
        dac_idle = 4'd0,     // zero on fast, mid-scale on slow
        dac_in1  = 4'd1,     // adc in1
        dac_in2  = 4'd2      // adc in2
    } dac_src_e;

    // trigger source, only the pin is wired
    typedef enum logic [7:0] {
        trig_pin = 8'd0      // external trigger input
    } trig_src_e;

endpackage

//--- hdl/scope_route.sv
`timescale 1ns/10ps

module scope_route (
    input  logic               clk,
    input  logic               rst,
    input  route_pkg::sample_t i_in1,
    input  route_pkg::sample_t i_in2,
    input  logic               i_external_trigger,
    output route_pkg::sample_t o_osc1,
    output route_pkg::sample_t o_osc2,
    output logic               o_trigger,   // one cycle tick per rising edge
    route_cfg_if.scope         cfg,
    route_mon_if.scope         mon
);

    logic trig_q;    // last sampled trigger level
    logic trig_en;   // pin selected as source

    // scope mux, everything past in2 is grounded
    function automatic route_pkg::sample_t pick(input route_pkg::scope_src_e sel,
                                                input route_pkg::sample_t    a,
                                                input route_pkg::sample_t    b);
        case (sel)
            route_pkg::scope_in1: return a;
            route_pkg::scope_in2: return b;
            default:              return '0;
        endcase
    endfunction

    // ------------------------------
    // scope channels
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_osc1 <= '0;
            o_osc2 <= '0;
        end else begin
            o_osc1 <= pick(cfg.osc_a_sel, i_in1, i_in2);   // one cycle behind input
            o_osc2 <= pick(cfg.osc_b_sel, i_in1, i_in2);
        end
    end

    // ------------------------------
    // trigger edge
    // ------------------------------
    assign trig_en = (cfg.trig_sel == route_pkg::trig_pin);   // other codes give nothing

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_q    <= 1'b0;
            o_trigger <= 1'b0;
        end else begin
            trig_q    <= i_external_trigger;
            o_trigger <= trig_en & i_external_trigger & ~trig_q;   // low then high
        end
    end

    // read-back taps
    assign mon.in1   = i_in1;
    assign mon.in2   = i_in2;
    assign mon.osc_a = o_osc1;
    assign mon.osc_b = o_osc2;

endmodule

//--- hdl/sig_config.svh
`ifndef SIG_CONFIG_SVH
`define SIG_CONFIG_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define SIG_W        14      // fast adc/dac sample
`define SLOW_W       12      // slow dac code
`define BUS_W        32      // system bus word

// ------------------------------
// slow dac scaling
// ------------------------------
`define SLOW_OFFSET  8192    // shifts signed range to 0..16383
`define SLOW_GAIN    156     // 16383*156 >> 10 lands near 2495
`define SLOW_SHIFT   10      // product lsbs dropped
`define MULT_STAGES  4       // offset, partials, sum, output

// ------------------------------
// bus decode
// ------------------------------
`define ADDR_DEC_W   20      // low address bits compared

`endif

//--- hdl/sig_router_top.sv
`timescale 1ns/10ps

module sig_router_top (
    input  logic                  clk,
    input  logic                  rst,
    // adc side
    input  route_pkg::sample_t    i_in1,
    input  route_pkg::sample_t    i_in2,
    input  logic                  i_external_trigger,
    // dac and scope side
    output route_pkg::sample_t    o_out1,
    output route_pkg::sample_t    o_out2,
    output route_pkg::sample_t    o_osc1,
    output route_pkg::sample_t    o_osc2,
    output logic                  o_trigger,
    output route_pkg::slow_code_t o_slow_out3,
    output route_pkg::slow_code_t o_slow_out4,
    output logic [1:0]            o_osc_ctrl,
    // system bus
    input  logic [31:0]           i_sys_addr,
    input  bus_pkg::bus_data_t    i_sys_wdata,
    input  logic                  i_sys_wen,
    input  logic                  i_sys_ren,
    output bus_pkg::bus_data_t    o_sys_rdata,
    output logic                  o_sys_ack
);

    route_cfg_if cfg_if ();   // switch settings
    route_mon_if mon_if ();   // live values for read-back

    sys_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .i_addr     (i_sys_addr),
        .i_wdata    (i_sys_wdata),
        .i_wen      (i_sys_wen),
        .i_ren      (i_sys_ren),
        .o_rdata    (o_sys_rdata),
        .o_ack      (o_sys_ack),
        .o_osc_ctrl (o_osc_ctrl),
        .cfg        (cfg_if.regs),
        .mon        (mon_if.regs)
    );

    scope_route u_scope (
        .clk                (clk),
        .rst                (rst),
        .i_in1              (i_in1),
        .i_in2              (i_in2),
        .i_external_trigger (i_external_trigger),
        .o_osc1             (o_osc1),
        .o_osc2             (o_osc2),
        .o_trigger          (o_trigger),
        .cfg                (cfg_if.scope),
        .mon                (mon_if.scope)
    );

    dac_route u_dac (
        .clk     (clk),
        .rst     (rst),
        .i_in1   (i_in1),
        .i_in2   (i_in2),
        .o_out1  (o_out1),
        .o_out2  (o_out2),
        .o_slow3 (o_slow_out3),
        .o_slow4 (o_slow_out4),
        .cfg     (cfg_if.dac),
        .mon     (mon_if.dac)
    );

endmodule

//--- hdl/slow_dac_scale.sv
`timescale 1ns/10ps
`include "sig_config.svh"

module slow_dac_scale (
    input  logic                  clk,
    input  logic                  rst,
    input  route_pkg::sample_t    i_sample,
    output route_pkg::slow_code_t o_code    // MULT_STAGES cycles later
);

    localparam int HALF       = `SIG_W / 2;          // split point of the operand
    localparam int GAIN_W     = 8;                   // 156 fits a byte
    localparam int PP_W       = HALF + GAIN_W;       // partial product width
    localparam int PROD_W     = `SIG_W + GAIN_W;     // full product, 22 bits
    localparam int PROD_DEPTH = `MULT_STAGES - 2;    // sum stage plus trailing delay

    localparam logic [GAIN_W-1:0] GAIN = GAIN_W'(`SLOW_GAIN);

    logic signed [`SIG_W:0]  off_sum;                // one extra bit for the add
    logic [`SIG_W-1:0]       off_q;                  // 0..16383 after offset
    logic [PP_W-1:0]         pp_lo;
    logic [PP_W-1:0]         pp_hi;
    logic [PROD_W-1:0]       prod_q [PROD_DEPTH];

    assign off_sum = (`SIG_W+1)'(i_sample) + (`SIG_W+1)'(`SLOW_OFFSET);

    // ------------------------------
    // offset, partials, sum, delay
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            off_q <= '0;
            pp_lo <= '0;
            pp_hi <= '0;
            for (int i = 0; i < PROD_DEPTH; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            off_q     <= off_sum[`SIG_W-1:0];                 // never negative here
            pp_lo     <= off_q[HALF-1:0] * GAIN;              // low half times gain
            pp_hi     <= off_q[`SIG_W-1:HALF] * GAIN;         // high half times gain
            prod_q[0] <= (PROD_W'(pp_hi) << HALF) + PROD_W'(pp_lo);
            for (int i = 1; i < PROD_DEPTH; i++) begin
                prod_q[i] <= prod_q[i-1];                     // balance to MULT_STAGES
            end
        end
    end

    // bits 21:10, full range gives 0..2495
    assign o_code = prod_q[PROD_DEPTH-1][`SLOW_SHIFT +: `SLOW_W];

endmodule

//--- hdl/sys_regs.sv
`timescale 1ns/10ps
`include "sig_config.svh"

module sys_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         i_addr,      // only low bits decoded
    input  bus_pkg::bus_data_t  i_wdata,
    input  logic                i_wen,
    input  logic                i_ren,
    output bus_pkg::bus_data_t  o_rdata,
    output logic                o_ack,
    output logic [1:0]          o_osc_ctrl,  // filter bypass bits to the scope
    route_cfg_if.regs           cfg,
    route_mon_if.regs           mon
);

    bus_pkg::reg_addr_e addr_dec;   // decoded register address
    bus_pkg::bus_data_t rd_word;    // read mux, sampled on access
    logic               sys_en;     // any access this cycle

    // sign extend a sample onto the bus
    function automatic bus_pkg::bus_data_t sext(input route_pkg::sample_t v);
        return {{(`BUS_W-`SIG_W){v[`SIG_W-1]}}, v};
    endfunction

    assign addr_dec = bus_pkg::reg_addr_e'(i_addr[`ADDR_DEC_W-1:0]);
    assign sys_en   = i_wen | i_ren;

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.osc_a_sel <= route_pkg::scope_in1;   // scope a shows in1
            cfg.osc_b_sel <= route_pkg::scope_in2;   // scope b shows in2
            o_osc_ctrl    <= 2'd3;                   // both filters off
            cfg.trig_sel  <= route_pkg::trig_pin;
            cfg.out1_sel  <= route_pkg::dac_idle;
            cfg.out2_sel  <= route_pkg::dac_idle;
            cfg.slow3_sel <= route_pkg::dac_idle;
            cfg.slow4_sel <= route_pkg::dac_idle;
        end else if (i_wen) begin
            case (addr_dec)
                bus_pkg::osc_a_sel: cfg.osc_a_sel <= route_pkg::scope_src_e'(i_wdata[4:0]);
                bus_pkg::osc_b_sel: cfg.osc_b_sel <= route_pkg::scope_src_e'(i_wdata[4:0]);
                bus_pkg::osc_ctrl:  o_osc_ctrl    <= i_wdata[1:0];
                bus_pkg::trig_sel:  cfg.trig_sel  <= route_pkg::trig_src_e'(i_wdata[7:0]);
                bus_pkg::out1_sel:  cfg.out1_sel  <= route_pkg::dac_src_e'(i_wdata[3:0]);
                bus_pkg::out2_sel:  cfg.out2_sel  <= route_pkg::dac_src_e'(i_wdata[3:0]);
                bus_pkg::slow3_sel: cfg.slow3_sel <= route_pkg::dac_src_e'(i_wdata[3:0]);
                bus_pkg::slow4_sel: cfg.slow4_sel <= route_pkg::dac_src_e'(i_wdata[3:0]);
                default: ;                           // live and unmapped, writes dropped
            endcase
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    always_comb begin
        case (addr_dec)
            bus_pkg::osc_a_sel: rd_word = bus_pkg::bus_data_t'(cfg.osc_a_sel);
            bus_pkg::osc_b_sel: rd_word = bus_pkg::bus_data_t'(cfg.osc_b_sel);
            bus_pkg::osc_ctrl:  rd_word = bus_pkg::bus_data_t'(o_osc_ctrl);
            bus_pkg::trig_sel:  rd_word = bus_pkg::bus_data_t'(cfg.trig_sel);
            bus_pkg::out1_sel:  rd_word = bus_pkg::bus_data_t'(cfg.out1_sel);
            bus_pkg::out2_sel:  rd_word = bus_pkg::bus_data_t'(cfg.out2_sel);
            bus_pkg::slow3_sel: rd_word = bus_pkg::bus_data_t'(cfg.slow3_sel);
            bus_pkg::slow4_sel: rd_word = bus_pkg::bus_data_t'(cfg.slow4_sel);
            bus_pkg::in1:       rd_word = sext(mon.in1);
            bus_pkg::in2:       rd_word = sext(mon.in2);
            bus_pkg::out1:      rd_word = sext(mon.out1);
            bus_pkg::out2:      rd_word = sext(mon.out2);
            bus_pkg::slow3:     rd_word = bus_pkg::bus_data_t'(mon.slow3);  // codes zero extend
            bus_pkg::slow4:     rd_word = bus_pkg::bus_data_t'(mon.slow4);
            bus_pkg::osc_a:     rd_word = sext(mon.osc_a);
            bus_pkg::osc_b:     rd_word = sext(mon.osc_b);
            default:            rd_word = '0;        // holes read zero, still acked
        endcase
    end

    // one ack per enable, next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= sys_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sys_en) begin
            o_rdata <= rd_word;                      // held until next access
        end
    end

endmodule

//--- sim/tb_sig_router.sv
`timescale 1ns/10ps
`include "sig_config.svh"

module tb_sig_router;

    localparam int N_ROWS      = 8;
    localparam int SLOW_LAT    = 5;     // selector reg plus multiplier stages
    localparam int STREAM_LEN  = 24;
    localparam int ACK_TIMEOUT = 16;    // cycles before an access is given up

    // select nibbles out1 out2 slow3 slow4 osc_a osc_b from the top down
    typedef struct packed {
        logic [23:0]           sel;
        route_pkg::sample_t    in1, in2;
        route_pkg::sample_t    exp_out1, exp_out2, exp_osc1, exp_osc2;
        route_pkg::slow_code_t exp_slow3, exp_slow4;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  ext_trig;
    logic                  trig_out;
    logic [1:0]            osc_ctrl;
    route_pkg::sample_t    in1, in2;
    route_pkg::sample_t    out1, out2, osc1, osc2;
    route_pkg::slow_code_t slow3, slow4;
    logic [31:0]           sys_addr, sys_wdata, sys_rdata;
    logic                  sys_wen, sys_ren, sys_ack;

    row_t   rows [N_ROWS];
    integer seed;
    int     errors;
    int     timeouts;

    sig_router_top uut (
        .clk(clk), .rst(rst), .i_in1(in1), .i_in2(in2), .i_external_trigger(ext_trig),
        .o_out1(out1), .o_out2(out2), .o_osc1(osc1), .o_osc2(osc2), .o_trigger(trig_out),
        .o_slow_out3(slow3), .o_slow_out4(slow4), .o_osc_ctrl(osc_ctrl),
        .i_sys_addr(sys_addr), .i_sys_wdata(sys_wdata), .i_sys_wen(sys_wen),
        .i_sys_ren(sys_ren), .o_sys_rdata(sys_rdata), .o_sys_ack(sys_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // ------------------------------
    // reference rules
    // ------------------------------

    // source 1 is in1 and 2 is in2 and anything else is zero
    function automatic route_pkg::sample_t routed(input logic [4:0] sel,
                                                  input route_pkg::sample_t a, b);
        case (sel)
            5'd1:    return a;
            5'd2:    return b;
            default: return '0;
        endcase
    endfunction

    // (x + offset) * gain keeping the bits from the shift up
    function automatic route_pkg::slow_code_t scaled(input logic [3:0] sel,
                                                     input route_pkg::sample_t a, b);
        int v;
        case (sel)
            4'd1:    v = a;
            4'd2:    v = b;
            default: return '0;                    // idle lands on code 0
        endcase
        v = (v + `SLOW_OFFSET) * `SLOW_GAIN;
        return v[`SLOW_SHIFT +: `SLOW_W];
    endfunction

    function automatic route_pkg::sample_t rand_sample();
        logic [31:0] v;
        v = $random(seed);
        return v[`SIG_W-1:0];
    endfunction

    function automatic logic [31:0] widen(input route_pkg::sample_t x);
        return {{(32-`SIG_W){x[`SIG_W-1]}}, x};   // sign bit copied up
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAILED time %0d ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    // ------------------------------
    // bus access
    // ------------------------------
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata);
        int n;
        @(negedge clk);
        sys_addr  = addr;
        sys_wdata = data;
        sys_wen   = wr;
        sys_ren   = ~wr;
        @(negedge clk);
        sys_wen = 1'b0;
        sys_ren = 1'b0;
        n = 0;
        while (sys_ack !== 1'b1 && n < ACK_TIMEOUT) begin   // ack due right now
            @(negedge clk);
            n++;
        end
        rdata = sys_rdata;                                   // valid with ack
        if (sys_ack !== 1'b1) begin
            timeouts++;
            $display("time %0d ns: no acknowledge for address %h", $time, addr);
        end else if (n != 0) begin
            errors++;
            $display("time %0d ns: acknowledge came %0d cycles late", $time, n);
        end
        @(negedge clk);
        if (sys_ack !== 1'b0) begin
            errors++;
            $display("time %0d ns: acknowledge held longer than one cycle", $time);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd_ignored;
        bus_access(1'b1, addr, data, rd_ignored);
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] got;
        bus_access(1'b0, addr, '0, got);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic build_table;
        logic [23:0] sel_tab [N_ROWS];
        sel_tab[0] = 24'h000012;   // every dac idle
        sel_tab[1] = 24'h121221;
        sel_tab[2] = 24'h212112;
        sel_tab[3] = 24'h110207;   // osc_b on an unused code
        sel_tab[4] = 24'h021030;
        sel_tab[5] = 24'h201190;
        sel_tab[6] = 24'h100221;
        sel_tab[7] = 24'h122112;   // full scale row
        for (int i = 0; i < N_ROWS; i++) begin
            rows[i].sel = sel_tab[i];
            if (i == N_ROWS - 1) begin
                rows[i].in1 = {1'b1, {(`SIG_W-1){1'b0}}};   // most negative
                rows[i].in2 = {1'b0, {(`SIG_W-1){1'b1}}};   // most positive
            end else begin
                rows[i].in1 = rand_sample();
                rows[i].in2 = rand_sample();
            end
            rows[i].exp_out1  = routed(5'(sel_tab[i][23:20]), rows[i].in1, rows[i].in2);
            rows[i].exp_out2  = routed(5'(sel_tab[i][19:16]), rows[i].in1, rows[i].in2);
            rows[i].exp_slow3 = scaled(sel_tab[i][15:12], rows[i].in1, rows[i].in2);
            rows[i].exp_slow4 = scaled(sel_tab[i][11:8], rows[i].in1, rows[i].in2);
            rows[i].exp_osc1  = routed(5'(sel_tab[i][7:4]), rows[i].in1, rows[i].in2);
            rows[i].exp_osc2  = routed(5'(sel_tab[i][3:0]), rows[i].in1, rows[i].in2);
        end
    endtask

    task automatic apply_row(input row_t r);
        bus_write(32'h00, 32'(r.sel[7:4]));
        bus_write(32'h04, 32'(r.sel[3:0]));
        bus_write(32'h10, 32'(r.sel[23:20]));
        bus_write(32'h14, 32'(r.sel[19:16]));
        bus_write(32'h20, 32'(r.sel[15:12]));
        bus_write(32'h24, 32'(r.sel[11:8]));
        @(negedge clk);
        in1 = r.in1;
        in2 = r.in2;
        #1;                                      // fast path in the same cycle
        if (out1 !== r.exp_out1) report_mismatch("o_out1", widen(out1), widen(r.exp_out1));
        if (out2 !== r.exp_out2) report_mismatch("o_out2", widen(out2), widen(r.exp_out2));
        @(negedge clk);                          // scope one cycle behind
        if (osc1 !== r.exp_osc1) report_mismatch("o_osc1", widen(osc1), widen(r.exp_osc1));
        if (osc2 !== r.exp_osc2) report_mismatch("o_osc2", widen(osc2), widen(r.exp_osc2));
        repeat (SLOW_LAT - 1) @(negedge clk);
        if (slow3 !== r.exp_slow3) report_mismatch("o_slow_out3", 32'(slow3), 32'(r.exp_slow3));
        if (slow4 !== r.exp_slow4) report_mismatch("o_slow_out4", 32'(slow4), 32'(r.exp_slow4));
    endtask

    // new sample every cycle with codes compared SLOW_LAT later
    task automatic run_stream;
        route_pkg::slow_code_t q3 [$];
        route_pkg::slow_code_t q4 [$];
        route_pkg::slow_code_t e3;
        route_pkg::slow_code_t e4;
        route_pkg::sample_t    prev1;
        route_pkg::sample_t    prev2;
        bus_write(32'h00, 32'd1);                // scope a on in1
        bus_write(32'h04, 32'd2);                // scope b on in2
        bus_write(32'h20, 32'd1);
        bus_write(32'h24, 32'd2);
        for (int k = 0; k < STREAM_LEN; k++) begin
            @(negedge clk);
            prev1 = in1;
            prev2 = in2;
            in1 = rand_sample();
            in2 = rand_sample();
            #1;                                  // scope still shows the last sample
            if (osc1 !== prev1) report_mismatch("o_osc1", widen(osc1), widen(prev1));
            if (osc2 !== prev2) report_mismatch("o_osc2", widen(osc2), widen(prev2));
            q3.push_back(scaled(4'd1, in1, in2));
            q4.push_back(scaled(4'd2, in1, in2));
            if (q3.size() > SLOW_LAT) begin
                e3 = q3.pop_front();
                e4 = q4.pop_front();
                if (slow3 !== e3) report_mismatch("o_slow_out3", 32'(slow3), 32'(e3));
                if (slow4 !== e4) report_mismatch("o_slow_out4", 32'(slow4), 32'(e4));
            end
        end
    endtask

    // raise the pin and count ticks over six cycles
    task automatic count_ticks(output int ticks, output int first);
        ticks = 0;
        first = -1;
        @(negedge clk);
        ext_trig = 1'b1;
        for (int k = 1; k <= 6; k++) begin
            @(negedge clk);
            if (trig_out === 1'b1) begin
                ticks++;
                if (first < 0) first = k;
            end
        end
        ext_trig = 1'b0;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int ticks;
        int first;
        seed      = 32'hf214;
        errors    = 0;
        timeouts  = 0;
        rst       = 1'b1;
        ext_trig  = 1'b0;
        in1       = '0;
        in2       = '0;
        sys_addr  = '0;
        sys_wdata = '0;
        sys_wen   = 1'b0;
        sys_ren   = 1'b0;
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        if (sys_ack !== 1'b0) report_mismatch("o_sys_ack", 32'(sys_ack), 32'd0);
        if (trig_out !== 1'b0) report_mismatch("o_trigger", 32'(trig_out), 32'd0);
        if (osc_ctrl !== 2'd3) report_mismatch("o_osc_ctrl", 32'(osc_ctrl), 32'd3);
        read_expect(32'h00, 32'd1, "osc_a_sel");
        read_expect(32'h04, 32'd2, "osc_b_sel");
        read_expect(32'h08, 32'd3, "osc_ctrl");
        for (int a = 'h0C; a <= 'h24; a += 4) begin
            read_expect(32'(a), 32'd0, $sformatf("select 0x%0h", a));
        end

        bus_write(32'h08, 32'hffff_fff1);        // upper bits fall outside the field
        if (osc_ctrl !== 2'd1) report_mismatch("o_osc_ctrl", 32'(osc_ctrl), 32'd1);
        read_expect(32'h08, 32'd1, "osc_ctrl");

        for (int i = 0; i < N_ROWS; i++) apply_row(rows[i]);

        // inputs still held from the full scale row
        read_expect(32'h28, widen(rows[N_ROWS-1].in1), "in1");
        read_expect(32'h2C, widen(rows[N_ROWS-1].in2), "in2");
        read_expect(32'h30, widen(rows[N_ROWS-1].exp_out1), "out1");
        read_expect(32'h34, widen(rows[N_ROWS-1].exp_out2), "out2");
        read_expect(32'h40, 32'(rows[N_ROWS-1].exp_slow3), "slow3");
        read_expect(32'h44, 32'(rows[N_ROWS-1].exp_slow4), "slow4");
        read_expect(32'h48, widen(rows[N_ROWS-1].exp_osc1), "osc_a");
        read_expect(32'h4C, widen(rows[N_ROWS-1].exp_osc2), "osc_b");
        read_expect(32'h3C, 32'd0, "unmapped 0x3c");
        read_expect(32'h1000, 32'd0, "unmapped 0x1000");

        run_stream();

        bus_write(32'h0C, 32'd0);                // pin
        count_ticks(ticks, first);
        if (ticks != 1) report_mismatch("o_trigger ticks", 32'(ticks), 32'd1);
        if (first != 1) report_mismatch("o_trigger delay", 32'(first), 32'd1);
        bus_write(32'h0C, 32'd3);                // nothing wired there
        count_ticks(ticks, first);
        if (ticks != 0) report_mismatch("o_trigger ticks", 32'(ticks), 32'd0);

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/route_pkg.sv
hdl/bus_pkg.sv
hdl/route_if.sv
hdl/sys_regs.sv
hdl/slow_dac_scale.sv
hdl/scope_route.sv
hdl/dac_route.sv
hdl/sig_router_top.sv
sim/tb_sig_router.sv
